// ==== list.f ====
+incdir+testbench
src/predecPkg.sv
src/predecCtrl.sv
src/boundaryFinder.sv
src/instrClassifier.sv
src/slotPacker.sv
src/jumpPicker.sv
src/predecTop.sv
testbench/predecTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module predecTb -o simv
out=$(./obj_dir/simv)
echo "$out"

if grep -qx "Test OK" <<< "$out"; then
  exit 0
else
  exit 1
fi

// ==== testbench/predecModel.svh ====
////////////////////
// reference model of the predecoder written from the decode rules
// positions past the bundle read halfword 0 and end bit 1
// include inside a module that imports predecPkg
////////////////////
`ifndef PREDEC_MODEL_SVH
`define PREDEC_MODEL_SVH

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [15:0] hwAt(input bundleT b, input int idx);
  if (idx >= numHalfwords) return 16'h0;
  return b.halfwords[idx*16 +: 16];
endfunction

function automatic logic endAt(input bundleT b, input int idx);
  if (idx >= numHalfwords) return 1'b1;
  return b.endBits[idx];
endfunction

function automatic classT modelClass(input logic [31:0] w, input logic [3:0] magic);
  classT c;
  logic [7:0] op;
  logic [5:0] sub;
  c   = '0;
  op  = w[7:0];
  sub = w[5:0];
  if (magic[0]) begin  // long form
    if (op inside {[0:31]}) begin
      c.alu = !op[2];
      c.mul = op[2];
    end else if (op inside {[40:45]}) c.shift = 1'b1;
    else if (op inside {[64:127]}) begin
      c.load  = !op[0];
      c.store = op[0];
    end else if (op inside {[160:175]}) begin
      c.jump = 1'b1;
      c.alu  = 1'b1;
    end else if (op == 8'd181) c.jump = 1'b1;
    else if (op == 8'd182) begin
      c.jump  = 1'b1;
      c.indir = 1'b1;
    end else if (op == 8'd255) c.sys = 1'b1;
  end else begin
    if (sub inside {[0:15]}) c.alu = 1'b1;
    else if (sub inside {[48:51]}) begin
      c.jump = 1'b1;
      c.alu  = 1'b1;
    end else if (sub inside {[16:31]} && sub[0]) c.shift = 1'b1;
  end
  return c;
endfunction

function automatic slotT modelSlot(input bundleT b, input int pos);
  slotT s;
  s.offset = offW'(pos);
  s.magic  = ~{endAt(b, pos + 3), endAt(b, pos + 2), endAt(b, pos + 1), endAt(b, pos)};
  s.instr  = {hwAt(b, pos + 1), hwAt(b, pos)};
  s.cls    = modelClass(s.instr, s.magic);
  return s;
endfunction

function automatic resultT modelResult(input bundleT b);
  resultT r;
  int pos;
  int n;
  int nj;
  r   = '0;
  pos = int'(b.startOff);
  n   = 0;
  for (int h = int'(b.startOff); h < numHalfwords; h++) begin
    if (b.endBits[h]) begin  // instr from pos to h is complete
      if (n < numSlots) begin
        r.slots[n]  = modelSlot(b, pos);
        r.slotEn[n] = 1'b1;
      end
      n   = n + 1;
      pos = h + 1;
    end
  end
  r.error = (n > numSlots);
  nj = 0;
  for (int i = 0; i < numSlots; i++) begin
    if (r.slotEn[i] && r.slots[i].cls.jump) begin
      if (nj < numJumpSlots) begin
        r.jumps[nj]  = r.slots[i];
        r.jumpEn[nj] = 1'b1;
      end
      nj = nj + 1;
    end
  end
  r.hasJumps  = (nj > 0);
  r.jumpError = (nj > numJumpSlots);
  return r;
endfunction

`endif

// ==== testbench/predecTb.sv ====
////////////////////
// testbench for predecTop against the model in predecModel.svh
// inputs change on the falling edge and outputs are sampled there too
////////////////////
`default_nettype none

module predecTb import predecPkg::*; ();

  `include "predecModel.svh"

  localparam int ackLimit = 20;  // edges before a wait gives up

  logic        clk;
  logic        arstN;
  logic        req;
  logic        ack;
  bundleT      bundleIn;
  resultT      result;
  logic [31:0] lfsr = 32'h2051_be72;
  int          errCnt = 0;
  int          checkCnt = 0;
  int          testCnt = 0;
  logic        timedOut = 1'b0;

  predecTop u_dut (
    .clk     (clk),
    .arstN   (arstN),
    .req     (req),
    .ack     (ack),
    .bundleIn(bundleIn),
    .result  (result)
  );

  always #2 clk = ~clk;

  task automatic checkField(input string name, input logic [511:0] exp, input logic [511:0] act);
    checkCnt = checkCnt + 1;
    assert (act === exp) else begin
      errCnt = errCnt + 1;
      $display("CHECK FAILED t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testCnt = testCnt + 1;
    $display("%s: %s", name, (errCnt == errBefore && !timedOut) ? "pass" : "fail");
  endtask

  task automatic randBits(input int n, output logic [255:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  task automatic randBundle(input logic [3:0] off, output bundleT b);
    logic [255:0] v;
    randBits(256, v);
    b.halfwords = v;
    randBits(16, v);
    b.endBits  = v[15:0];
    b.startOff = off;
  endtask

  // 8 long-form instrs of 2 halfwords with opcode i in ops[i*8 +: 8]
  task automatic longBundle(input logic [63:0] ops, output bundleT b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b.halfwords[i*32 +: 16]      = {8'h5a, ops[i*8 +: 8]};
      b.halfwords[i*32 + 16 +: 16] = 16'(i);
    end
    b.endBits = 16'haaaa;
  endtask

  task automatic shortBundle(input logic [47:0] subs, output bundleT b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b.halfwords[i*16 +: 16] = {10'h0, subs[i*6 +: 6]};
    end
    b.endBits = 16'hffff;  // every halfword is an instr
  endtask

  task automatic checkResult(input resultT exp);
    checkField("result.slots", 512'(exp.slots), 512'(result.slots));
    checkField("result.slotEn", 512'(exp.slotEn), 512'(result.slotEn));
    checkField("result.jumps", 512'(exp.jumps), 512'(result.jumps));
    checkField("result.jumpEn", 512'(exp.jumpEn), 512'(result.jumpEn));
    checkField("result.hasJumps", 512'(exp.hasJumps), 512'(result.hasJumps));
    checkField("result.error", 512'(exp.error), 512'(result.error));
    checkField("result.jumpError", 512'(exp.jumpError), 512'(result.jumpError));
  endtask

  // one full four-phase transfer with req held for holdCycles after ack
  task automatic runReq(input bundleT b, input int holdCycles);
    resultT exp;
    int     n;
    if (timedOut) return;
    exp = modelResult(b);
    @(negedge clk);
    bundleIn = b;
    req      = 1'b1;
    n = 0;
    while (!ack && !timedOut) begin
      @(negedge clk);
      n = n + 1;
      if (n > ackLimit) begin
        timedOut = 1'b1;
        $display("timeout: ack never rose after req");
      end
    end
    if (timedOut) return;
    checkField("ack rise edges", 512'(2), 512'(n));
    checkResult(exp);
    for (int k = 0; k < holdCycles; k++) begin
      @(negedge clk);
      checkField("ack", 512'(1), 512'(ack));
      checkField("result", 512'(exp), 512'(result));
    end
    req = 1'b0;
    n = 0;
    while (ack && !timedOut) begin
      @(negedge clk);
      n = n + 1;
      if (n > ackLimit) begin
        timedOut = 1'b1;
        $display("timeout: ack never fell after req dropped");
      end
    end
    checkField("ack fall edges", 512'(1), 512'(n));
  endtask

  initial begin
    int           e;
    bundleT       b;
    logic [255:0] v;
    clk      = 1'b0;
    arstN    = 1'b0;
    req      = 1'b0;
    bundleIn = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    e = errCnt;
    checkField("ack", 512'(0), 512'(ack));
    checkField("result", 512'(0), 512'(result));
    reportTest("reset", e);

    e = errCnt;
    randBundle(4'd0, b);
    runReq(b, 4);
    runReq(b, 1);
    reportTest("handshake", e);

    e = errCnt;
    for (int k = 0; k < 12; k++) begin
      randBundle(4'd0, b);
      runReq(b, 0);
    end
    b.endBits = 16'hffff;  // 16 instrs, more than the slots
    runReq(b, 0);
    checkField("result.error", 512'(1), 512'(result.error));
    reportTest("random boundaries", e);

    e = errCnt;
    for (int k = 0; k < 8; k++) begin
      randBits(4, v);
      randBundle((v[3:0] == 4'd0) ? 4'd1 : v[3:0], b);
      runReq(b, 0);
    end
    b.startOff = 4'd5;
    b.endBits  = 16'hffff;
    runReq(b, 0);
    checkField("result.slots[0].offset", 512'(5), 512'(result.slots[0].offset));
    reportTest("start offset", e);

    e = errCnt;
    longBundle(64'hb6b5aa51_502a0405, b);
    runReq(b, 0);
    checkField("result.slots[7].cls", 512'(8'b0000_0110), 512'(result.slots[7].cls));
    longBundle(64'h01010101_0101c8ff, b);
    runReq(b, 0);
    checkField("result.slots[0].cls", 512'(8'b0000_0001), 512'(result.slots[0].cls));
    checkField("result.slots[1].cls", 512'(0), 512'(result.slots[1].cls));  // 200 unknown
    shortBundle({6'd63, 6'd18, 6'd31, 6'd17, 6'd51, 6'd48, 6'd15, 6'd0}, b);
    runReq(b, 0);
    reportTest("classes", e);

    e = errCnt;
    longBundle(64'h01010101_01010101, b);
    runReq(b, 0);
    longBundle(64'h01010101_01b50101, b);
    runReq(b, 0);
    longBundle(64'h0101b601_01b50101, b);
    runReq(b, 0);
    longBundle(64'h01b601aa_01b50101, b);
    runReq(b, 0);
    checkField("result.jumpError", 512'(1), 512'(result.jumpError));
    reportTest("jumps", e);

    $display("%0d tests, %0d checks, %0d errors", testCnt, checkCnt, errCnt);
    if (errCnt == 0 && !timedOut) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/predecTop.sv ====
////////////////////
// predecoder top with a req/ack handshake on bundleIn and result
// result valid while ack is high
////////////////////
`default_nettype none

module predecTop import predecPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  logic   req,
  output logic   ack,
  input  bundleT bundleIn,
  output resultT result
);

  bundleT                        bundleQ;
  logic [numSlots-1:0][offW-1:0] starts;
  logic [numSlots-1:0]           slotEn;
  logic                          error;
  slotT [numSlots-1:0]           slots;
  slotT [numJumpSlots-1:0]       jumps;
  logic [numJumpSlots-1:0]       jumpEn;
  logic                          hasJumps;
  logic                          jumpError;
  resultT                        nextResult;

  assign nextResult = '{slots: slots, slotEn: slotEn, jumps: jumps, jumpEn: jumpEn,
                        hasJumps: hasJumps, error: error, jumpError: jumpError};

  predecCtrl u_ctrl (
    .clk       (clk),
    .arstN     (arstN),
    .req       (req),
    .ack       (ack),
    .bundleIn  (bundleIn),
    .bundleQ   (bundleQ),
    .nextResult(nextResult),
    .result    (result)
  );

  boundaryFinder u_bound (
    .bundle(bundleQ),
    .starts(starts),
    .slotEn(slotEn),
    .error (error)
  );

  slotPacker u_pack (
    .bundle(bundleQ),
    .starts(starts),
    .slotEn(slotEn),
    .slots (slots)
  );

  jumpPicker u_jump (
    .slots    (slots),
    .slotEn   (slotEn),
    .jumps    (jumps),
    .jumpEn   (jumpEn),
    .hasJumps (hasJumps),
    .jumpError(jumpError)
  );

endmodule

`default_nettype wire

// ==== src/jumpPicker.sv ====
////////////////////
// first two jump slots in slot order
// jumpError when more than two jumps are present
////////////////////
`default_nettype none

module jumpPicker import predecPkg::*; (
  input  slotT [numSlots-1:0]     slots,
  input  logic [numSlots-1:0]     slotEn,
  output slotT [numJumpSlots-1:0] jumps,
  output logic [numJumpSlots-1:0] jumpEn,
  output logic                    hasJumps,
  output logic                    jumpError
);

  logic [numSlots-1:0] isJmp;

  always_comb begin
    for (int i = 0; i < numSlots; i++) begin
      isJmp[i] = slotEn[i] & slots[i].cls.jump;
    end
  end

  always_comb begin
    int jmpCnt;
    jmpCnt = 0;
    jumps  = '0;
    jumpEn = '0;
    for (int i = 0; i < numSlots; i++) begin
      if (isJmp[i]) begin
        if (jmpCnt < numJumpSlots) begin
          jumps[jmpCnt]  = slots[i];
          jumpEn[jmpCnt] = 1'b1;
        end
        jmpCnt = jmpCnt + 1;
      end
    end
    jumpError = (jmpCnt > numJumpSlots);
  end

  assign hasJumps = |isJmp;

endmodule

`default_nettype wire

// ==== src/slotPacker.sv ====
////////////////////
// every halfword position is classified and slots pick by start index
// halfwords past the bundle end read 0 and their end bits read 1
// disabled slots are all zero
////////////////////
`default_nettype none

module slotPacker import predecPkg::*; (
  input  bundleT                        bundle,
  input  logic [numSlots-1:0][offW-1:0] starts,
  input  logic [numSlots-1:0]           slotEn,
  output slotT [numSlots-1:0]           slots
);

  logic [numHalfwords*16+instrW-16-1:0] hwExt;
  logic [numHalfwords+2:0]              endExt;
  logic [numHalfwords-1:0][3:0]         magicArr;
  logic [numHalfwords-1:0][instrW-1:0]  winArr;
  classT [numHalfwords-1:0]             clsArr;

  assign hwExt  = {{(instrW-16){1'b0}}, bundle.halfwords};
  assign endExt = {3'b111, bundle.endBits};

  for (genvar h = 0; h < numHalfwords; h++) begin : g_pos
    assign magicArr[h] = ~endExt[h+3:h];
    assign winArr[h]   = hwExt[h*16 +: instrW];

    instrClassifier u_cls (
      .instr(winArr[h]),
      .magic(magicArr[h]),
      .cls  (clsArr[h])
    );
  end

  always_comb begin
    for (int i = 0; i < numSlots; i++) begin
      slots[i] = '0;
      if (slotEn[i]) begin
        slots[i].offset = starts[i];
        slots[i].magic  = magicArr[starts[i]];
        slots[i].instr  = winArr[starts[i]];
        slots[i].cls    = clsArr[starts[i]];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/instrClassifier.sv ====
////////////////////
// class vector for one halfword position
// magic bit 0 selects long form (8-bit opcode) or short form (6-bit)
// unknown opcodes give a zero class
////////////////////
`default_nettype none

module instrClassifier import predecPkg::*; (
  input  logic [instrW-1:0] instr,
  input  logic [3:0]        magic,
  output classT             cls
);

  logic [7:0] opc;
  logic [5:0] sub;

  assign opc = instr[7:0];
  assign sub = instr[5:0];

  always_comb begin
    cls = '0;
    if (magic[0]) begin
      if (opc <= opAluMax) begin
        if (opc[2]) cls.mul = 1'b1;
        else        cls.alu = 1'b1;
      end else if (opc >= opShiftLo && opc <= opShiftHi) begin
        cls.shift = 1'b1;
      end else if (opc >= opMemLo && opc <= opMemHi) begin
        if (opc[0]) cls.store = 1'b1;
        else        cls.load  = 1'b1;
      end else if (opc >= opBranchLo && opc <= opBranchHi) begin
        cls.jump = 1'b1;  // compare and branch
        cls.alu  = 1'b1;
      end else if (opc == opJump) begin
        cls.jump = 1'b1;
      end else if (opc == opIndir) begin
        cls.jump  = 1'b1;
        cls.indir = 1'b1;
      end else if (opc == opSys) begin
        cls.sys = 1'b1;
      end
    end else begin
      if (sub <= subAluMax) begin
        cls.alu = 1'b1;
      end else if (sub >= subBranchLo && sub <= subBranchHi) begin
        cls.jump = 1'b1;
        cls.alu  = 1'b1;
      end else if (sub >= subShiftLo && sub <= subShiftHi && sub[0]) begin
        cls.shift = 1'b1;  // even values here are unassigned
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/boundaryFinder.sv ====
////////////////////
// instruction starts from end bits at or after startOff
// an instr without a closing end bit in the bundle is not counted
// error when more than 8 instructions are found
////////////////////
`default_nettype none

module boundaryFinder import predecPkg::*; (
  input  bundleT                        bundle,
  output logic [numSlots-1:0][offW-1:0] starts,
  output logic [numSlots-1:0]           slotEn,
  output logic                          error
);

  always_comb begin
    int endCnt;
    endCnt    = 0;
    starts    = '0;
    starts[0] = bundle.startOff;
    for (int h = 0; h < numHalfwords; h++) begin
      // halfwords below startOff are masked
      if (h >= int'(bundle.startOff) && bundle.endBits[h]) begin
        endCnt = endCnt + 1;
        if (endCnt < numSlots) begin
          starts[endCnt] = offW'(h + 1);  // next instr after this end
        end
      end
    end

    for (int i = 0; i < numSlots; i++) begin
      slotEn[i] = (endCnt > i);
    end
    error = (endCnt > numSlots);
  end

endmodule

`default_nettype wire

// ==== src/predecCtrl.sv ====
////////////////////
// four-phase req/ack wrapper around the decode
// bundleIn must stay stable while req is high
// one bundle in flight, result frozen while ack is high
////////////////////
`default_nettype none

module predecCtrl import predecPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  logic   req,
  output logic   ack,
  input  bundleT bundleIn,
  output bundleT bundleQ,
  input  resultT nextResult,
  output resultT result
);

  ctrlStateE state;
  ctrlStateE stateNext;

  always_comb begin
    stateNext = state;
    case (state)
      idle: begin
        if (req) stateNext = busy;
      end
      busy: stateNext = hold;  // decode settles in one cycle
      hold: begin
        if (!req) stateNext = idle;
      end
      default: stateNext = idle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state  <= idle;
      ack    <= 1'b0;
      result <= '0;
    end else begin
      state <= stateNext;
      ack   <= (stateNext == hold);
      if (state == busy) begin
        result <= nextResult;
      end
    end
  end

  // captured once per accepted request
  always_ff @(posedge clk) begin
    if (state == idle && req) begin
      bundleQ <= bundleIn;
    end
  end

endmodule

`default_nettype wire

// ==== src/predecPkg.sv ====
////////////////////
// shared widths, enums and structs for the predecoder
// a bundle is 16 halfwords, an end bit marks the last halfword of an instr
// only 8 slots and 2 jump slots are reported
////////////////////
`default_nettype none

package predecPkg;

  localparam int numHalfwords = 16;
  localparam int numSlots     = 8;
  localparam int numJumpSlots = 2;
  localparam int offW         = 4;   // halfword index
  localparam int instrW       = 32;  // bits reported per slot

  // short form sub-opcode cuts
  localparam logic [5:0] subAluMax   = 6'd15;
  localparam logic [5:0] subShiftLo  = 6'd16;
  localparam logic [5:0] subShiftHi  = 6'd31;
  localparam logic [5:0] subBranchLo = 6'd48;
  localparam logic [5:0] subBranchHi = 6'd51;

  // long form opcode group cuts
  typedef enum logic [7:0] {
    opAluMax   = 8'd31,
    opShiftLo  = 8'd40,
    opShiftHi  = 8'd45,
    opMemLo    = 8'd64,
    opMemHi    = 8'd127,
    opBranchLo = 8'd160,
    opBranchHi = 8'd175,
    opJump     = 8'd181,
    opIndir    = 8'd182,
    opSys      = 8'd255
  } opcodeE;

  typedef enum logic [1:0] {idle, busy, hold} ctrlStateE;

  typedef struct packed {
    logic [numHalfwords*16-1:0] halfwords;
    logic [numHalfwords-1:0]    endBits;
    logic [offW-1:0]            startOff;
  } bundleT;

  typedef struct packed {
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic jump;
    logic indir;
    logic sys;
  } classT;

  typedef struct packed {
    logic [offW-1:0]   offset;
    logic [3:0]        magic;
    logic [instrW-1:0] instr;
    classT             cls;
  } slotT;  // 48 bits

  typedef struct packed {
    slotT [numSlots-1:0]     slots;
    logic [numSlots-1:0]     slotEn;
    slotT [numJumpSlots-1:0] jumps;
    logic [numJumpSlots-1:0] jumpEn;
    logic                    hasJumps;
    logic                    error;
    logic                    jumpError;
  } resultT;

endpackage

`default_nettype wire
